//--- common/mcu_cfg.svh
// sizing and interrupt bit positions for the power-management block
// include wherever domain counts or vector positions are needed

`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// power domains, banks are the last indices
`define MCU_NUM_DOMAINS 4
`define MCU_NUM_BANKS 2

`define MCU_NUM_FAST_IRQ 15

// core interrupt vector positions
`define MCU_IRQ_MSIP 3
`define MCU_IRQ_MTIP 7
`define MCU_IRQ_MEIP 11
`define MCU_IRQ_FAST_LSB 16

`endif

//--- common/mcu_pkg.sv
// types shared by the power controller, the sequencers and the interrupt packer
// import with mcu_pkg::* in the module header

`include "mcu_cfg.svh"

package mcu_pkg;

  // all bits active low, all high means domain fully on
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef pwr_ctrl_out_t [`MCU_NUM_DOMAINS-1:0] pwr_ctrl_out_arr_t;

  typedef enum logic [1:0] {
    PWR_CMD_NONE,
    PWR_CMD_OFF,
    PWR_CMD_ON,
    PWR_CMD_RET
  } pwr_cmd_e;

  typedef enum logic [1:0] {
    DOM_CPU,
    DOM_PERIPH,
    DOM_BANK0,
    DOM_BANK1
  } domain_e;

  typedef enum logic [3:0] {
    SEQ_ON,
    SEQ_CLK_OFF,
    SEQ_ISO,
    SEQ_RST,
    SEQ_SWITCH_OFF,
    SEQ_OFF,
    SEQ_SWITCH_ON,
    SEQ_RST_REL,
    SEQ_ISO_REL,
    SEQ_RET,
    SEQ_RET_EXIT
  } seq_state_e;

  typedef struct packed {
    logic       sw;
    logic       ext;
    logic [3:0] timer;
    logic       dma_done;
    logic       spi;
    logic       spi_flash;
    logic [7:0] gpio_ao;
  } irq_src_t;

endpackage

//--- power/domain_sequencer.sv
// gating sequence for one power domain, steps one control bit per cycle
// and waits on the power-switch acknowledge, done pulses at the end

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module domain_sequencer
  import mcu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  pwr_cmd_e      cmd_i,
  input  logic          ack_n_i,
  output pwr_ctrl_out_t ctrl_o,
  output seq_state_e    state_o,
  output logic          done_o
);

  seq_state_e    state_q;
  seq_state_e    state_d;
  pwr_ctrl_out_t ctrl_q;
  pwr_ctrl_out_t ctrl_d;
  pwr_cmd_e      cmd_q;
  logic          done_q;
  logic          done_d;

  always_comb begin
    state_d = state_q;
    ctrl_d  = ctrl_q;
    done_d  = 1'b0;
    case (state_q)
      SEQ_ON: begin
        // off and retention both start by stopping the clock
        if (start_i && (cmd_i == PWR_CMD_OFF || cmd_i == PWR_CMD_RET)) begin
          state_d             = SEQ_CLK_OFF;
          ctrl_d.clkgate_en_n = 1'b0;
        end
      end
      SEQ_CLK_OFF: begin
        if (cmd_q == PWR_CMD_RET) begin
          state_d               = SEQ_RET;
          ctrl_d.retentive_en_n = 1'b0;
          done_d                = 1'b1;
        end else begin
          state_d             = SEQ_ISO;
          ctrl_d.isogate_en_n = 1'b0;
        end
      end
      SEQ_ISO: begin
        state_d      = SEQ_RST;
        ctrl_d.rst_n = 1'b0;
      end
      SEQ_RST: begin
        state_d             = SEQ_SWITCH_OFF;
        ctrl_d.pwrgate_en_n = 1'b0;
      end
      SEQ_SWITCH_OFF: begin
        // a bank switched off from retention drops retention here
        if (!ack_n_i) begin
          state_d               = SEQ_OFF;
          ctrl_d.retentive_en_n = 1'b1;
          done_d                = 1'b1;
        end
      end
      SEQ_OFF: begin
        if (start_i && cmd_i == PWR_CMD_ON) begin
          state_d             = SEQ_SWITCH_ON;
          ctrl_d.pwrgate_en_n = 1'b1;
        end
      end
      SEQ_SWITCH_ON: begin
        if (ack_n_i) begin
          state_d      = SEQ_RST_REL;
          ctrl_d.rst_n = 1'b1;
        end
      end
      SEQ_RST_REL: begin
        state_d             = SEQ_ISO_REL;
        ctrl_d.isogate_en_n = 1'b1;
      end
      SEQ_ISO_REL, SEQ_RET_EXIT: begin
        state_d             = SEQ_ON;
        ctrl_d.clkgate_en_n = 1'b1;
        done_d              = 1'b1;
      end
      SEQ_RET: begin
        if (start_i && cmd_i == PWR_CMD_ON) begin
          state_d               = SEQ_RET_EXIT;
          ctrl_d.retentive_en_n = 1'b1;
        end else if (start_i && cmd_i == PWR_CMD_OFF) begin
          // clock already gated
          state_d             = SEQ_ISO;
          ctrl_d.isogate_en_n = 1'b0;
        end
      end
      default: state_d = SEQ_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_ON;
      ctrl_q  <= '1;
      cmd_q   <= PWR_CMD_NONE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
      done_q  <= done_d;
      if (start_i) begin
        cmd_q <= cmd_i;
      end
    end
  end

  assign ctrl_o  = ctrl_q;
  assign state_o = state_q;
  assign done_o  = done_q;

endmodule

//--- power/power_ctrl.sv
// accepts power commands, checks them against the target's state and
// starts one domain sequencer at a time, wake requests become a CPU power-on

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module power_ctrl
  import mcu_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cmd_valid_i,
  input  pwr_cmd_e                           cmd_i,
  input  domain_e                            domain_i,
  input  logic                               wake_i,
  input  seq_state_e [`MCU_NUM_DOMAINS-1:0]  seq_state_i,
  input  logic [`MCU_NUM_DOMAINS-1:0]        seq_done_i,
  output logic [`MCU_NUM_DOMAINS-1:0]        seq_start_o,
  output pwr_cmd_e                           seq_cmd_o,
  output logic                               busy_o
);

  logic       busy_q;
  domain_e    active_q;
  seq_state_e target_state;
  logic       is_bank;
  logic       cmd_legal;
  logic       take_cmd;
  logic       take_wake;
  logic       accept;
  domain_e    target;

  assign target_state = seq_state_i[domain_i];
  assign is_bank = int'(domain_i) >= (`MCU_NUM_DOMAINS - `MCU_NUM_BANKS);

  // only banks may retain, and only from fully on
  always_comb begin
    case (cmd_i)
      PWR_CMD_OFF: cmd_legal = target_state != SEQ_OFF;
      PWR_CMD_ON:  cmd_legal = target_state != SEQ_ON;
      PWR_CMD_RET: cmd_legal = is_bank && (target_state == SEQ_ON);
      default:     cmd_legal = 1'b0;
    endcase
  end

  // an explicit command wins over a pending wake
  assign take_cmd  = cmd_valid_i && !busy_q && cmd_legal;
  assign take_wake = wake_i && !busy_q && !take_cmd;
  assign accept    = take_cmd || take_wake;
  assign target    = take_cmd ? domain_i : DOM_CPU;
  assign seq_cmd_o = take_cmd ? cmd_i : PWR_CMD_ON;

  always_comb begin
    for (int d = 0; d < `MCU_NUM_DOMAINS; d++) begin
      seq_start_o[d] = accept && (int'(target) == d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      active_q <= DOM_CPU;
    end else if (accept) begin
      busy_q   <= 1'b1;
      active_q <= target;
    end else if (busy_q && seq_done_i[active_q]) begin
      busy_q <= 1'b0;
    end
  end

  assign busy_o = busy_q;

endmodule

//--- source/irq_vector.sv
// packs the interrupt sources into the core's 32-bit vector and fast field
// masks peripheral sources under isolation and flags wake for an off CPU

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module irq_vector
  import mcu_pkg::*;
(
  input  irq_src_t    src_i,
  input  logic        periph_iso_n_i,
  input  logic        cpu_off_i,
  output logic [31:0] irq_o,
  output logic        wake_o
);

  logic [`MCU_NUM_FAST_IRQ-1:0] fast;
  logic                         sw_m;
  logic                         ext_m;
  logic                         timer2_m;
  logic                         timer3_m;
  logic                         spi_m;

  // peripheral domain sources read zero while it is isolated
  assign sw_m     = src_i.sw && periph_iso_n_i;
  assign ext_m    = src_i.ext && periph_iso_n_i;
  assign timer2_m = src_i.timer[2] && periph_iso_n_i;
  assign timer3_m = src_i.timer[3] && periph_iso_n_i;
  assign spi_m    = src_i.spi && periph_iso_n_i;

  // top fast bit unused
  assign fast = {
    1'b0,
    src_i.gpio_ao,
    src_i.spi_flash,
    spi_m,
    src_i.dma_done,
    timer3_m,
    timer2_m,
    src_i.timer[1]
  };

  always_comb begin
    irq_o = '0;
    irq_o[`MCU_IRQ_MSIP] = sw_m;
    irq_o[`MCU_IRQ_MTIP] = src_i.timer[0];
    irq_o[`MCU_IRQ_MEIP] = ext_m;
    irq_o[`MCU_IRQ_FAST_LSB +: `MCU_NUM_FAST_IRQ] = fast;
  end

  assign wake_o = cpu_off_i && (|irq_o);

endmodule

//--- source/mini_mcu_top.sv
// power-management top: control, one sequencer per domain and the interrupt
// packer, with the debug reset merged into every domain reset

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          debug_reset_n_i,
  input  logic                          pwr_cmd_valid_i,
  input  pwr_cmd_e                      pwr_cmd_i,
  input  domain_e                       pwr_domain_i,
  input  logic [`MCU_NUM_DOMAINS-1:0]   pwr_ack_n_i,
  input  logic                          core_sleep_i,
  input  irq_src_t                      irq_src_i,
  output pwr_ctrl_out_arr_t             pwr_ctrl_o,
  output logic                          pwr_busy_o,
  output logic [31:0]                   irq_o
);

  pwr_ctrl_out_arr_t                 seq_ctrl;
  seq_state_e [`MCU_NUM_DOMAINS-1:0] seq_state;
  logic [`MCU_NUM_DOMAINS-1:0]       seq_start;
  logic [`MCU_NUM_DOMAINS-1:0]       seq_done;
  pwr_cmd_e                          seq_cmd;
  logic                              cpu_off;
  logic                              irq_wake;
  logic                              wake;

  assign cpu_off = seq_state[DOM_CPU] == SEQ_OFF;
  // wake only a sleeping core or a switched-off CPU domain
  assign wake = irq_wake && (core_sleep_i || cpu_off);

  power_ctrl u_power_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (pwr_cmd_valid_i),
    .cmd_i       (pwr_cmd_i),
    .domain_i    (pwr_domain_i),
    .wake_i      (wake),
    .seq_state_i (seq_state),
    .seq_done_i  (seq_done),
    .seq_start_o (seq_start),
    .seq_cmd_o   (seq_cmd),
    .busy_o      (pwr_busy_o)
  );

  for (genvar i = 0; i < `MCU_NUM_DOMAINS; i++) begin : g_dom
    domain_sequencer u_seq (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .start_i (seq_start[i]),
      .cmd_i   (seq_cmd),
      .ack_n_i (pwr_ack_n_i[i]),
      .ctrl_o  (seq_ctrl[i]),
      .state_o (seq_state[i]),
      .done_o  (seq_done[i])
    );
  end

  // domain reset also follows the debug module's reset
  always_comb begin
    pwr_ctrl_o = seq_ctrl;
    for (int d = 0; d < `MCU_NUM_DOMAINS; d++) begin
      pwr_ctrl_o[d].rst_n = seq_ctrl[d].rst_n && debug_reset_n_i;
    end
  end

  irq_vector u_irq_vector (
    .src_i          (irq_src_i),
    .periph_iso_n_i (seq_ctrl[DOM_PERIPH].isogate_en_n),
    .cpu_off_i      (cpu_off),
    .irq_o          (irq_o),
    .wake_o         (irq_wake)
  );

endmodule

//--- bench/mini_mcu_assert.sv
// concurrent checks on the power-management top, bound into mini_mcu_top
// failed goes high at the first failing assertion

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mini_mcu_assert
  import mcu_pkg::*;
(
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        pwr_cmd_valid_i,
  input pwr_cmd_e                    pwr_cmd_i,
  input domain_e                     pwr_domain_i,
  input logic [`MCU_NUM_DOMAINS-1:0] pwr_ack_n_i,
  input irq_src_t                    irq_src_i,
  input pwr_ctrl_out_arr_t           pwr_ctrl_o,
  input logic                        pwr_busy_o,
  input logic [31:0]                 irq_o,
  input logic [`MCU_NUM_DOMAINS-1:0] seq_start
);

  logic                        failed = 1'b0;
  logic [`MCU_NUM_DOMAINS-1:0] active_q;
  pwr_cmd_e                    last_cmd_q;

  function automatic void report_failure(input string msg);
    failed = 1'b1;
    $error("%s", msg);
  endfunction

  // reference bit map, peripheral sources masked by isolation
  function automatic logic [31:0] expected_irq(input irq_src_t s, input logic iso_n);
    logic [31:0] v;
    v        = '0;
    v[3]     = s.sw & iso_n;
    v[7]     = s.timer[0];
    v[11]    = s.ext & iso_n;
    v[16]    = s.timer[1];
    v[17]    = s.timer[2] & iso_n;
    v[18]    = s.timer[3] & iso_n;
    v[19]    = s.dma_done;
    v[20]    = s.spi & iso_n;
    v[21]    = s.spi_flash;
    v[29:22] = s.gpio_ao;
    return v;
  endfunction

  // resting bundle once a sequence has finished
  function automatic logic [4:0] expected_end(input pwr_cmd_e c);
    case (c)
      PWR_CMD_OFF: return 5'b00001;
      PWR_CMD_RET: return 5'b11100;
      default:     return 5'b11111;
    endcase
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q   <= '0;
      last_cmd_q <= PWR_CMD_NONE;
    end else if (|seq_start) begin
      active_q   <= seq_start;
      // a start without a strobe is a wake-up
      last_cmd_q <= pwr_cmd_valid_i ? pwr_cmd_i : PWR_CMD_ON;
    end
  end

  a_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (pwr_ctrl_o == '1) && !pwr_busy_o)
    else report_failure($sformatf("FAIL %0t pwr_ctrl_o/pwr_busy_o got %h/%b expected fffff/0",
      $time, pwr_ctrl_o, pwr_busy_o));

  a_irq_map: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o == expected_irq(irq_src_i, pwr_ctrl_o[DOM_PERIPH].isogate_en_n))
    else report_failure($sformatf("FAIL %0t irq_o got %h expected %h", $time, irq_o,
      expected_irq(irq_src_i, pwr_ctrl_o[DOM_PERIPH].isogate_en_n)));

  // retention to a non-bank domain is dropped
  a_ret_dropped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pwr_cmd_valid_i && !pwr_busy_o && pwr_cmd_i == PWR_CMD_RET
      && int'(pwr_domain_i) < (`MCU_NUM_DOMAINS - `MCU_NUM_BANKS) && irq_o == '0
    |=> !pwr_busy_o && $stable(pwr_ctrl_o))
    else report_failure("retention command to a non-bank domain was not dropped");

  a_wake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pwr_busy_o && !pwr_cmd_valid_i && pwr_ctrl_o[DOM_CPU] == 5'b00001 && irq_o != '0
    |=> pwr_busy_o && pwr_ctrl_o[DOM_CPU].pwrgate_en_n)
    else report_failure("pending interrupt did not start a CPU power-on");

  for (genvar d = 0; d < `MCU_NUM_DOMAINS; d++) begin : g_dom
    a_off_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pwr_ctrl_o[d].pwrgate_en_n |-> !pwr_ctrl_o[d].rst_n && !pwr_ctrl_o[d].isogate_en_n
        && !pwr_ctrl_o[d].clkgate_en_n)
      else report_failure($sformatf("domain %0d switched off with reset, iso or clock open", d));

    a_rst_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pwr_ctrl_o[d].rst_n |-> !pwr_ctrl_o[d].isogate_en_n)
      else report_failure($sformatf("domain %0d in reset without isolation", d));

    a_on_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pwr_ctrl_o[d].pwrgate_en_n && !pwr_ack_n_i[d] |-> !pwr_ctrl_o[d].rst_n)
      else report_failure($sformatf("domain %0d left reset before the switch acknowledged", d));

    a_clk_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pwr_cmd_valid_i && !pwr_busy_o && int'(pwr_domain_i) == d && pwr_ctrl_o[d] == 5'b11111
        && (pwr_cmd_i == PWR_CMD_OFF || (pwr_cmd_i == PWR_CMD_RET
        && d >= (`MCU_NUM_DOMAINS - `MCU_NUM_BANKS)))
      |=> $fell(pwr_ctrl_o[d].clkgate_en_n))
      else report_failure($sformatf("domain %0d clock gate did not close one cycle after accept", d));

    // idle domains rest fully on, fully off or in retention
    a_idle_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pwr_busy_o |-> pwr_ctrl_o[d] == 5'b11111 || pwr_ctrl_o[d] == 5'b00001
        || pwr_ctrl_o[d] == 5'b11100)
      else report_failure($sformatf("FAIL %0t pwr_ctrl_o[%0d] got %b expected 11111/00001/11100",
        $time, d, pwr_ctrl_o[d]));

    // the sequenced domain ends in the state its command asked for
    a_seq_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(pwr_busy_o) && active_q[d] |-> pwr_ctrl_o[d] == expected_end(last_cmd_q))
      else report_failure($sformatf("FAIL %0t pwr_ctrl_o[%0d] got %b expected %b",
        $time, d, pwr_ctrl_o[d], expected_end(last_cmd_q)));

    a_busy_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pwr_busy_o && pwr_cmd_valid_i && !active_q[d] |=> $stable(pwr_ctrl_o[d]))
      else report_failure($sformatf("strobe while busy changed idle domain %0d", d));
  end

endmodule

//--- bench/tb_clock.sv
// free-running 4 ns testbench clock and a reset held low for 16 cycles

`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/mini_mcu_tb.sv
// testbench for the power-management top: drives power commands and interrupt
// sources and models the power switches, the bound assertions do the checking

`timescale 1ns/1ps
`include "mcu_cfg.svh"

module mini_mcu_tb;
  import mcu_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic                        clk;
  logic                        rst_n;
  logic                        debug_reset_n;
  logic                        cmd_valid;
  pwr_cmd_e                    cmd;
  domain_e                     domain;
  wire [`MCU_NUM_DOMAINS-1:0]  ack_n;
  logic                        core_sleep;
  irq_src_t                    irq_src;
  pwr_ctrl_out_arr_t           pwr_ctrl;
  logic                        busy;
  logic [31:0]                 irq;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mini_mcu_top uut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .debug_reset_n_i (debug_reset_n),
    .pwr_cmd_valid_i (cmd_valid),
    .pwr_cmd_i       (cmd),
    .pwr_domain_i    (domain),
    .pwr_ack_n_i     (ack_n),
    .core_sleep_i    (core_sleep),
    .irq_src_i       (irq_src),
    .pwr_ctrl_o      (pwr_ctrl),
    .pwr_busy_o      (busy),
    .irq_o           (irq)
  );

  bind mini_mcu_top mini_mcu_assert u_chk (.*);

  // switch model, acknowledge follows the enable after 1 to 8 cycles
  for (genvar d = 0; d < `MCU_NUM_DOMAINS; d++) begin : g_switch
    logic        ack_q = 1'b1;
    int unsigned lag;
    assign ack_n[d] = ack_q;
    always begin
      @(posedge clk);
      #1;
      if (ack_q != pwr_ctrl[d].pwrgate_en_n) begin
        lag = $urandom_range(8, 1);
        repeat (lag) @(posedge clk);
        #1;
        ack_q = pwr_ctrl[d].pwrgate_en_n;
      end
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped on timeout");
  endtask

  task automatic wait_reset_release();
    int cycles = 0;
    while (rst_n !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("reset release");
      end
      @(posedge clk);
      cycles++;
    end
    #1;
  endtask

  task automatic wait_idle();
    int cycles = 0;
    while (busy) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("the power controller to go idle");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_cpu_reset_release();
    int cycles = 0;
    while (!pwr_ctrl[DOM_CPU].rst_n) begin
      if (cycles == WAIT_LIMIT) begin
        report_timeout("the CPU domain reset to release");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  // one-cycle strobe, called 1 ns after a rising edge
  task automatic send_cmd(input pwr_cmd_e c, input domain_e d);
    cmd_valid = 1'b1;
    cmd       = c;
    domain    = d;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd       = PWR_CMD_NONE;
  endtask

  task automatic drive_random_irq(input int count);
    logic [31:0] rnd;
    repeat (count) begin
      rnd     = $urandom;
      irq_src = rnd[$bits(irq_src_t)-1:0];
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin
    if (uut.u_chk.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "assertion failure reported");
    end
  end

  initial begin
    void'($urandom(32'h8711_fee0));
    debug_reset_n = 1'b1;
    cmd_valid     = 1'b0;
    cmd           = PWR_CMD_NONE;
    domain        = DOM_CPU;
    core_sleep    = 1'b0;
    irq_src       = '0;
    wait_reset_release();

    // peripheral domain off, sources sampled under isolation
    send_cmd(PWR_CMD_OFF, DOM_PERIPH);
    wait_idle();
    drive_random_irq(32);
    send_cmd(PWR_CMD_ON, DOM_PERIPH);
    wait_idle();
    drive_random_irq(32);
    irq_src = '0;

    // bank 1 retention, the bank 0 strobe lands while busy
    send_cmd(PWR_CMD_RET, DOM_BANK1);
    send_cmd(PWR_CMD_OFF, DOM_BANK0);
    wait_idle();
    send_cmd(PWR_CMD_ON, DOM_BANK1);
    wait_idle();
    send_cmd(PWR_CMD_RET, DOM_CPU);
    wait_idle();

    // CPU off, then timer 0 wakes it
    send_cmd(PWR_CMD_OFF, DOM_CPU);
    wait_idle();
    core_sleep       = 1'b1;
    irq_src.timer[0] = 1'b1;
    wait_cpu_reset_release();
    wait_idle();
    irq_src    = '0;
    core_sleep = 1'b0;
    repeat (4) @(posedge clk);
    #1;

    if (uut.u_chk.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "assertion failure reported");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+common
common/mcu_pkg.sv
power/domain_sequencer.sv
power/power_ctrl.sv
source/irq_vector.sv
source/mini_mcu_top.sv
bench/mini_mcu_assert.sv
bench/tb_clock.sv
bench/mini_mcu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module mini_mcu_tb \
  -o mini_mcu_sim || exit 1
./obj_dir/mini_mcu_sim +verilator+error+limit+100 > sim.log 2>&1
grep -q "=== PASS ===" sim.log && echo "simulation passed" || {
  echo "simulation failed, see sim.log"
  exit 1
}
